//--- filelist.f
+incdir+design
design/qdr_align_pkg.sv
design/qdr_tap_pkg.sv
design/qdr_phy_bit_train.sv
design/qdr_phy_bit_correct.sv
design/qdr_phy_bit_align.sv
sim/qdr_phy_checker.sv
sim/qdr_phy_monitor.sv
sim/qdr_phy_tb.sv

//--- Makefile
TOP = qdr_phy_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

//--- sim/qdr_phy_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_phy_defines.svh"

module qdr_phy_tb;
  import qdr_tap_pkg::*;

  localparam int W          = `QDR_DATA_WIDTH;
  localparam int TIMEOUT    = 3000;
  localparam int WORDS      = 200;
  localparam int NUM_TESTS  = 5;

  logic         clk0 = 1'b0;
  logic         reset;
  logic         bit_align_start;
  logic         bit_align_done, bit_align_fail, qdr_w_n, qdr_r_n;
  logic [W-1:0] dly_inc_dec_n, dly_en, dly_rst;
  logic [W-1:0] qdr_q_rise, qdr_q_fall, qdr_q_rise_cal, qdr_q_fall_cal;
  logic [W-1:0] model_rise, model_fall, prev_fall;
  logic         model_valid;
  logic         stream;
  int           words_left;
  tap_t         tap_emu [W];   // Emulated delay line position per lane
  int           lo [W];
  int           width [W];
  bit           has_win [W];
  bit           shift [W];     // Lane arrives half a cycle late
  bit           aborted;

  always #20 clk0 = ~clk0;

  qdr_phy_bit_align UUT (
    .clk0 (clk0), .reset (reset), .bit_align_start (bit_align_start),
    .bit_align_done (bit_align_done), .bit_align_fail (bit_align_fail),
    .dly_inc_dec_n (dly_inc_dec_n), .dly_en (dly_en), .dly_rst (dly_rst),
    .qdr_w_n (qdr_w_n), .qdr_r_n (qdr_r_n),
    .qdr_q_rise (qdr_q_rise), .qdr_q_fall (qdr_q_fall),
    .qdr_q_rise_cal (qdr_q_rise_cal), .qdr_q_fall_cal (qdr_q_fall_cal)
  );

  qdr_phy_monitor mon (
    .clk0 (clk0), .bit_align_start (bit_align_start),
    .bit_align_done (bit_align_done), .bit_align_fail (bit_align_fail),
    .qdr_w_n (qdr_w_n), .qdr_r_n (qdr_r_n), .dly_en (dly_en), .dly_rst (dly_rst),
    .dly_inc_dec_n (dly_inc_dec_n), .qdr_q_rise_cal (qdr_q_rise_cal),
    .qdr_q_fall_cal (qdr_q_fall_cal), .model_rise (model_rise),
    .model_fall (model_fall), .model_valid (model_valid)
  );

  // ************************************************************************
  // Delay line and SRAM emulation
  // ************************************************************************

  always @(posedge clk0) begin
    for (int i = 0; i < W; i++) begin
      if (reset || dly_rst[i]) tap_emu[i] <= '0;
      else if (dly_en[i] && dly_inc_dec_n[i]) tap_emu[i] <= tap_emu[i] + 1'b1;
    end
  end

  always @(posedge clk0) begin
    #2;
    if (stream) begin
      model_rise  = W'($urandom);
      model_fall  = W'($urandom);
      model_valid = (words_left > 0);
      if (words_left > 0) words_left--;
      for (int i = 0; i < W; i++) begin
        qdr_q_rise[i] = shift[i] ? prev_fall[i] : model_rise[i];
        qdr_q_fall[i] = shift[i] ? model_rise[i] : model_fall[i];
      end
      prev_fall = model_fall;
    end else begin
      model_valid = 1'b0;
      for (int i = 0; i < W; i++) begin
        // Training word of rise 1 and fall 0 is seen only inside the eye
        if (has_win[i] && int'(tap_emu[i]) >= lo[i] && int'(tap_emu[i]) < lo[i] + width[i]) begin
          qdr_q_rise[i] = !shift[i];
          qdr_q_fall[i] = shift[i];
        end else begin
          qdr_q_rise[i] = 1'b0;
          qdr_q_fall[i] = 1'b0;
        end
      end
    end
  end

  // ************************************************************************
  // Test sequencing
  // ************************************************************************

  task automatic apply_reset();
    @(posedge clk0);
    #2 reset = 1'b1;
    repeat (8) @(posedge clk0);
    #2 reset = 1'b0;
  endtask

  task automatic draw_windows(input bit with_hole);
    int hole;
    for (int i = 0; i < W; i++) begin
      width[i]   = 3 + int'($urandom % 8);
      lo[i]      = int'($urandom % (`QDR_TAP_COUNT - width[i] + 1));
      shift[i]   = 1'($urandom % 2);
      has_win[i] = 1'b1;
    end
    if (with_hole) begin
      hole          = int'($urandom % W);
      has_win[hole] = 1'b0;
    end
  endtask

  task automatic run_test(input int t);
    bit fail_test;
    int n;
    fail_test = (t == NUM_TESTS - 1);
    mon.start_test(fail_test ? "no_window" : $sformatf("calibrate_%0d", t));
    draw_windows(fail_test);
    apply_reset();
    @(negedge clk0);
    mon.check_reset();
    mon.arm_strobes();
    @(posedge clk0);
    #2 bit_align_start = 1'b1;
    @(posedge clk0);
    #2 bit_align_start = 1'b0;
    for (n = 0; n < TIMEOUT && !bit_align_done; n++) @(negedge clk0);
    if (!bit_align_done) begin
      mon.note_timeout("calibration done");
      aborted = 1'b1;
    end else begin
      @(negedge clk0);
      mon.check_strobes();
      for (int i = 0; i < W; i++) begin
        mon.check_centre(i, lo[i], width[i], has_win[i], int'(tap_emu[i]));
      end
      mon.check_fail(fail_test);
      if (!fail_test) begin
        words_left = WORDS;
        stream     = 1'b1;
        for (n = 0; n < TIMEOUT && words_left > 0; n++) @(posedge clk0);
        if (words_left > 0) begin
          mon.note_timeout("the data stream");
          aborted = 1'b1;
        end
        repeat (4) @(posedge clk0);  // Last word still needs the next rise
        stream = 1'b0;
        repeat (3) @(posedge clk0);
      end
    end
    mon.end_test();
  endtask

  initial begin
    void'($urandom(32'h87bc5b57));
    reset           = 1'b1;
    bit_align_start = 1'b0;
    qdr_q_rise      = '0;
    qdr_q_fall      = '0;
    model_rise      = '0;
    model_fall      = '0;
    prev_fall       = '0;
    model_valid     = 1'b0;
    stream          = 1'b0;
    words_left      = 0;
    aborted         = 1'b0;
    for (int i = 0; i < W; i++) begin
      has_win[i] = 1'b0;
      shift[i]   = 1'b0;
      lo[i]      = 0;
      width[i]   = 0;
    end
    for (int t = 0; t < NUM_TESTS && !aborted; t++) run_test(t);
    $display("Tests run: %0d, failed: %0d", mon.tests_run, mon.tests_failed);
    if (mon.tests_failed == 0 && !aborted) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/qdr_phy_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_phy_defines.svh"

module qdr_phy_monitor (
  input wire                       clk0,
  input wire                       bit_align_start,
  input wire                       bit_align_done,
  input wire                       bit_align_fail,
  input wire                       qdr_w_n,
  input wire                       qdr_r_n,
  input wire [`QDR_DATA_WIDTH-1:0] dly_en,
  input wire [`QDR_DATA_WIDTH-1:0] dly_rst,
  input wire [`QDR_DATA_WIDTH-1:0] dly_inc_dec_n,
  input wire [`QDR_DATA_WIDTH-1:0] qdr_q_rise_cal,
  input wire [`QDR_DATA_WIDTH-1:0] qdr_q_fall_cal,
  input wire [`QDR_DATA_WIDTH-1:0] model_rise,
  input wire [`QDR_DATA_WIDTH-1:0] model_fall,
  input wire                       model_valid
);

  int    tests_run;
  int    tests_failed;
  int    test_errs;
  int    data_errs;
  string test_name;
  bit    armed;
  int    cyc;
  int    start_cyc;
  int    w_cnt;
  int    w_cyc;
  int    r_first;
  int    rst_first;   // First dly_rst, one cycle after train_start
  int    last_dly;    // Latest tap movement on any lane
  int    done_cyc;
  bit    r_early;
  bit    r_at_done;
  logic [`QDR_DATA_WIDTH-1:0] r1, f1, r2, f2;  // Expected words 1 and 2 cycles old
  bit    v1, v2;

  initial begin
    tests_run    = 0;
    tests_failed = 0;
    armed        = 0;
    v1           = 0;
    v2           = 0;
  end

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
    data_errs = 0;
  endtask

  task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
    test_errs++;
  endtask

  task automatic problem(input string what);
    $display("Test %s: %s", test_name, what);
    test_errs++;
  endtask

  task automatic check_reset();
    if (bit_align_done !== 1'b0) mismatch("done after reset", 0, 32'(bit_align_done));
    if (bit_align_fail !== 1'b0) mismatch("fail after reset", 0, 32'(bit_align_fail));
    if (dly_en !== '0) mismatch("dly_en after reset", 0, 32'(dly_en));
    if (dly_rst !== '0) mismatch("dly_rst after reset", 0, 32'(dly_rst));
    if (dly_inc_dec_n !== '0) mismatch("dly_inc_dec_n after reset", 0, 32'(dly_inc_dec_n));
    if (qdr_w_n !== 1'b1) mismatch("qdr_w_n after reset", 1, 32'(qdr_w_n));
    if (qdr_r_n !== 1'b1) mismatch("qdr_r_n after reset", 1, 32'(qdr_r_n));
  endtask

  task automatic arm_strobes();
    cyc       = 0;
    start_cyc = -1;
    w_cnt     = 0;
    w_cyc     = -1;
    r_first   = -1;
    rst_first = -1;
    last_dly  = -1;
    done_cyc  = -1;
    r_early   = 0;
    armed     = 1;
  endtask

  task automatic check_strobes();
    armed = 0;
    if (w_cnt != 1) mismatch("write strobe cycles", 1, w_cnt);
    if (w_cyc != start_cyc + 1) mismatch("write strobe cycle", start_cyc + 1, w_cyc);
    if (r_first != w_cyc + 1) mismatch("read strobe start cycle", w_cyc + 1, r_first);
    // Read wait runs QDR_READ_WAIT+1 cycles, then every lane resets its taps
    if (rst_first != r_first + `QDR_READ_WAIT + 1) begin
      mismatch("training start cycle", r_first + `QDR_READ_WAIT + 1, rst_first);
    end
    if (r_early) problem("read strobe went high before done");
    if (!r_at_done) problem("read strobe still low when done rose");
    // Last lane finishes, the sequencer leaves TRAIN, then the finish wait
    if (done_cyc - last_dly < `QDR_FINISH_WAIT + 2) begin
      mismatch("cycles from last tap move to done", `QDR_FINISH_WAIT + 2, done_cyc - last_dly);
    end
  endtask

  // Centre of lo..lo+width-1 or tap 0 for a lane without a window
  task automatic check_centre(input int lane, input int lo, input int width,
                              input bit has_win, input int act);
    int exp;
    exp = has_win ? (lo + lo + width - 1) / 2 : 0;
    if (act != exp) mismatch($sformatf("lane %0d tap", lane), exp, act);
  endtask

  task automatic check_fail(input bit exp);
    if (bit_align_fail !== exp) mismatch("fail flag", 32'(exp), 32'(bit_align_fail));
  endtask

  task automatic note_timeout(input string what);
    problem($sformatf("timed out waiting for %s", what));
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("Test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", test_name, test_errs);
    end
  endtask

  always @(negedge clk0) begin
    if (armed) begin
      cyc++;
      if (bit_align_start && start_cyc < 0) start_cyc = cyc;
      if (!qdr_w_n) begin
        w_cnt++;
        w_cyc = cyc;
      end
      if (!qdr_r_n && r_first < 0) r_first = cyc;
      if (dly_rst != '0 && rst_first < 0) rst_first = cyc;
      if (dly_en != '0 || dly_rst != '0) last_dly = cyc;
      if (qdr_r_n && r_first >= 0 && !bit_align_done) r_early = 1;
      if (bit_align_done && done_cyc < 0) begin
        done_cyc  = cyc;
        r_at_done = qdr_r_n;
      end
    end
    // Word k is due two cycles after its rise half went in
    if (v2 && (qdr_q_rise_cal !== r2 || qdr_q_fall_cal !== f2)) begin
      if (data_errs < 4) begin
        mismatch("calibrated rise word", 32'(r2), 32'(qdr_q_rise_cal));
        mismatch("calibrated fall word", 32'(f2), 32'(qdr_q_fall_cal));
      end else begin
        test_errs++;
      end
      data_errs++;
    end
    r2 = r1;
    f2 = f1;
    v2 = v1;
    r1 = model_rise;
    f1 = model_fall;
    v1 = model_valid;
  end

endmodule

`default_nettype wire

//--- sim/qdr_phy_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_phy_defines.svh"

module qdr_phy_checker (
  input wire                       clk0,
  input wire                       reset,
  input wire                       bit_align_done,
  input wire                       bit_align_fail,
  input wire                       qdr_w_n,
  input wire                       qdr_r_n,
  input wire [`QDR_DATA_WIDTH-1:0] dly_en
);

  // ************************************************************************
  // Strobe and status rules
  // ************************************************************************

  single_write: assert property (@(posedge clk0) disable iff (reset)
    !qdr_w_n |=> qdr_w_n)
    else $error("write strobe low for two cycles");

  // Tap moves only while reads return the training word
  taps_during_read: assert property (@(posedge clk0) disable iff (reset)
    |dly_en |-> !qdr_r_n)
    else $error("delay increment outside the read window");

  done_sticky: assert property (@(posedge clk0) disable iff (reset)
    bit_align_done |=> bit_align_done)
    else $error("done dropped without reset");

  fail_with_done: assert property (@(posedge clk0) disable iff (reset)
    bit_align_fail |-> bit_align_done)
    else $error("fail raised before done");

endmodule

bind qdr_phy_bit_align qdr_phy_checker u_checker (
  .clk0           (clk0),
  .reset          (reset),
  .bit_align_done (bit_align_done),
  .bit_align_fail (bit_align_fail),
  .qdr_w_n        (qdr_w_n),
  .qdr_r_n        (qdr_r_n),
  .dly_en         (dly_en)
);

`default_nettype wire

//--- design/qdr_phy_bit_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_phy_defines.svh"

module qdr_phy_bit_align (
  input  wire                        clk0,
  input  wire                        reset,

  input  wire                        bit_align_start,
  output logic                       bit_align_done,
  output logic                       bit_align_fail,

  output wire  [`QDR_DATA_WIDTH-1:0] dly_inc_dec_n,
  output wire  [`QDR_DATA_WIDTH-1:0] dly_en,
  output wire  [`QDR_DATA_WIDTH-1:0] dly_rst,

  output logic                       qdr_w_n,
  output logic                       qdr_r_n,
  input  wire  [`QDR_DATA_WIDTH-1:0] qdr_q_rise,
  input  wire  [`QDR_DATA_WIDTH-1:0] qdr_q_fall,

  output wire  [`QDR_DATA_WIDTH-1:0] qdr_q_rise_cal,
  output wire  [`QDR_DATA_WIDTH-1:0] qdr_q_fall_cal
);
  import qdr_align_pkg::*;

  localparam int READ_W   = $clog2(`QDR_READ_WAIT + 1);
  localparam int FINISH_W = $clog2(`QDR_FINISH_WAIT + 1);

  align_state_t               state;
  logic [READ_W-1:0]          read_wait;
  logic [FINISH_W-1:0]        finish_wait;
  logic                       fail_q;       // Any lane without a window
  logic                       train_start;
  logic [`QDR_DATA_WIDTH-1:0] train_done;
  logic [`QDR_DATA_WIDTH-1:0] train_fail;
  logic [`QDR_DATA_WIDTH-1:0] aligned;

  // ************************************************************************
  // Calibration sequencer
  // ************************************************************************

  // Last cycle of the read wait kicks off every lane
  assign train_start = (state == ALIGN_WAIT) && (read_wait == '0);

  always_ff @(posedge clk0) begin
    if (reset) begin
      state  <= ALIGN_IDLE;
      fail_q <= 1'b0;
    end else begin
      case (state)
        ALIGN_IDLE: begin
          if (bit_align_start) state <= ALIGN_WRITE;
        end

        ALIGN_WRITE: begin
          read_wait <= READ_W'(`QDR_READ_WAIT);
          state     <= ALIGN_WAIT;
        end

        ALIGN_WAIT: begin
          if (read_wait != '0) begin
            read_wait <= read_wait - 1'b1;
          end else begin
            state <= ALIGN_TRAIN;
          end
        end

        ALIGN_TRAIN: begin
          if (&train_done) begin
            fail_q      <= |train_fail;
            finish_wait <= '0;
            state       <= ALIGN_FINISH;
          end
        end

        ALIGN_FINISH: begin
          if (finish_wait == FINISH_W'(`QDR_FINISH_WAIT)) begin
            state <= ALIGN_DONE;
          end else begin
            finish_wait <= finish_wait + 1'b1;
          end
        end

        ALIGN_DONE: begin
          // Stay until reset
        end

        default: state <= ALIGN_IDLE;
      endcase
    end
  end

  assign bit_align_done = (state == ALIGN_DONE);
  assign bit_align_fail = fail_q && (state == ALIGN_DONE);  // Reported with done

  // SRAM strobes, active low
  assign qdr_w_n = (state != ALIGN_WRITE);
  assign qdr_r_n = !(state == ALIGN_WAIT || state == ALIGN_TRAIN ||
                     state == ALIGN_FINISH);

  // ************************************************************************
  // Lane arrays
  // ************************************************************************

  qdr_phy_bit_train u_train [`QDR_DATA_WIDTH-1:0] (
    .clk0          (clk0),
    .reset         (reset),
    .train_start   (train_start),
    .q_rise        (qdr_q_rise),
    .q_fall        (qdr_q_fall),
    .train_done    (train_done),
    .train_fail    (train_fail),
    .aligned       (aligned),
    .dly_inc_dec_n (dly_inc_dec_n),
    .dly_en        (dly_en),
    .dly_rst       (dly_rst)
  );

  // Re-pairs half-cycle late lanes into whole words
  qdr_phy_bit_correct u_correct [`QDR_DATA_WIDTH-1:0] (
    .clk0       (clk0),
    .reset      (reset),
    .aligned    (aligned),
    .q_rise     (qdr_q_rise),
    .q_fall     (qdr_q_fall),
    .q_rise_cal (qdr_q_rise_cal),
    .q_fall_cal (qdr_q_fall_cal)
  );

endmodule

`default_nettype wire

//--- design/qdr_phy_bit_correct.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_phy_bit_correct (
  input  wire  clk0,
  input  wire  reset,
  input  wire  aligned,
  input  wire  q_rise,
  input  wire  q_fall,
  output logic q_rise_cal,
  output logic q_fall_cal
);

  logic rise_d1;
  logic fall_d1;

  // First stage, raw capture
  always_ff @(posedge clk0) begin
    rise_d1 <= q_rise;
    fall_d1 <= q_fall;
  end

  // Second stage picks the pairing
  // A late lane carries the word start on fall and its end on the next rise
  always_ff @(posedge clk0) begin
    if (reset) begin
      q_rise_cal <= 1'b0;
      q_fall_cal <= 1'b0;
    end else if (aligned) begin
      q_rise_cal <= rise_d1;
      q_fall_cal <= fall_d1;
    end else begin
      q_rise_cal <= fall_d1;  // Fall of the starting cycle
      q_fall_cal <= q_rise;   // Rise of the following cycle
    end
  end

endmodule

`default_nettype wire

//--- design/qdr_phy_bit_train.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_phy_defines.svh"

module qdr_phy_bit_train (
  input  wire  clk0,
  input  wire  reset,
  input  wire  train_start,
  input  wire  q_rise,
  input  wire  q_fall,
  output logic train_done,
  output logic train_fail,
  output logic aligned,
  output logic dly_inc_dec_n,
  output logic dly_en,
  output logic dly_rst
);
  import qdr_tap_pkg::*;

  localparam int SETTLE_W = $clog2(`QDR_SETTLE_CYCLES + 1);

  train_state_t          state;
  tap_t                  tap;         // Tap the delay line is at
  tap_t                  first_tap;
  tap_t                  last_tap;
  tap_t                  center_tap;
  logic [SETTLE_W-1:0]   settle_cnt;
  logic [`QDR_TAP_BITS:0] tap_sum;
  logic                  found;       // Window start seen
  logic                  centred;     // Back at the centre tap
  logic                  gap;         // Spaces out centring pulses
  logic                  valid;

  // Training word is rise 1, fall 0, so a clean eye gives differing halves
  assign valid      = q_rise ^ q_fall;
  assign tap_sum    = {1'b0, first_tap} + {1'b0, last_tap};
  assign center_tap = tap_sum[`QDR_TAP_BITS:1];
  assign train_done = (state == TRAIN_DONE);

  always_ff @(posedge clk0) begin
    if (reset) begin
      state         <= TRAIN_RESET;
      train_fail    <= 1'b0;
      aligned       <= 1'b0;
      found         <= 1'b0;
      centred       <= 1'b0;
      gap           <= 1'b0;
      dly_en        <= 1'b0;
      dly_inc_dec_n <= 1'b0;
      dly_rst       <= 1'b0;
    end else begin
      dly_en        <= 1'b0;  // All delay controls are single pulses
      dly_inc_dec_n <= 1'b0;
      dly_rst       <= 1'b0;

      case (state)
        TRAIN_RESET: begin
          if (train_start) begin
            dly_rst    <= 1'b1;
            tap        <= '0;
            found      <= 1'b0;
            centred    <= 1'b0;
            train_fail <= 1'b0;
            aligned    <= 1'b0;
            settle_cnt <= '0;
            state      <= TRAIN_SETTLE;
          end
        end

        TRAIN_SETTLE: begin
          if (settle_cnt == SETTLE_W'(`QDR_SETTLE_CYCLES - 1)) begin
            state <= TRAIN_SAMPLE;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end

        TRAIN_SAMPLE: begin
          if (centred) begin
            // Rise low at the centre means the lane is half a cycle late
            aligned <= q_rise;
            state   <= TRAIN_DONE;
          end else begin
            if (valid) begin
              if (!found) first_tap <= tap;
              last_tap <= tap;
              found    <= 1'b1;
            end
            if ((valid || !found) && tap != TAP_LAST) begin
              state <= TRAIN_STEP;
            end else if (valid || found) begin
              dly_rst <= 1'b1;       // Run ended or taps exhausted
              tap     <= '0;
              gap     <= 1'b1;       // Keep rst and first en apart
              state   <= TRAIN_CENTER;
            end else begin
              dly_rst    <= 1'b1;    // No eye, park at tap 0
              tap        <= '0;
              train_fail <= 1'b1;
              state      <= TRAIN_DONE;
            end
          end
        end

        TRAIN_STEP: begin
          dly_en        <= 1'b1;
          dly_inc_dec_n <= 1'b1;
          tap           <= tap + 1'b1;
          settle_cnt    <= '0;
          state         <= TRAIN_SETTLE;
        end

        TRAIN_CENTER: begin
          if (gap) begin
            gap <= 1'b0;
          end else if (tap == center_tap) begin
            centred    <= 1'b1;
            settle_cnt <= '0;
            state      <= TRAIN_SETTLE;
          end else begin
            dly_en        <= 1'b1;
            dly_inc_dec_n <= 1'b1;
            tap           <= tap + 1'b1;
            gap           <= 1'b1;
          end
        end

        TRAIN_DONE: begin
          // Result held until reset
        end

        default: state <= TRAIN_RESET;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/qdr_tap_pkg.sv
`default_nettype none

`include "qdr_phy_defines.svh"

package qdr_tap_pkg;

  // Delay tap index
  typedef logic [`QDR_TAP_BITS-1:0] tap_t;

  localparam tap_t TAP_LAST = tap_t'(`QDR_TAP_COUNT - 1);

  // Per lane trainer
  typedef enum logic [2:0] {
    TRAIN_RESET  = 3'd0,  // Idle until train_start
    TRAIN_SETTLE = 3'd1,
    TRAIN_SAMPLE = 3'd2,
    TRAIN_STEP   = 3'd3,  // One increment pulse
    TRAIN_CENTER = 3'd4,  // Walk back to window centre
    TRAIN_DONE   = 3'd5
  } train_state_t;

endpackage

`default_nettype wire

//--- design/qdr_align_pkg.sv
`default_nettype none

// ************************************************************************
// Bit alignment sequencer
// ************************************************************************

package qdr_align_pkg;

  // Top level calibration flow
  typedef enum logic [2:0] {
    ALIGN_IDLE   = 3'd0,  // Waiting for start
    ALIGN_WRITE  = 3'd1,  // Single training write
    ALIGN_WAIT   = 3'd2,  // Read latency
    ALIGN_TRAIN  = 3'd3,  // Lanes sweep their taps
    ALIGN_FINISH = 3'd4,
    ALIGN_DONE   = 3'd5   // Held until reset
  } align_state_t;

endpackage

`default_nettype wire

//--- design/qdr_phy_defines.svh
`ifndef QDR_PHY_DEFINES_SVH
`define QDR_PHY_DEFINES_SVH

// ************************************************************************
// Read calibration sizing
// ************************************************************************

// Read data lanes, one trainer and one corrector each
`define QDR_DATA_WIDTH 18

// Input delay line
`define QDR_TAP_COUNT 32
`define QDR_TAP_BITS 5

// Cycles between a tap change and its sample
`define QDR_SETTLE_CYCLES 4

// Sequencer wait lengths
`define QDR_READ_WAIT 15    // Write to first read data
`define QDR_FINISH_WAIT 7   // Trailing reads after training

`endif
